//--- Makefile
# Verilator build and run for the vector floating-point pipeline

VERILATOR ?= verilator
TOP ?= fp_vector_pipe_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

# The log decides the outcome, the exit status of the pipe does not
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/fp_add_stage.sv
/*
 * FP pipeline stage 3, add
 * Adds or subtracts the aligned significands, extended with guard,
 * round and sticky bits and a carry bit. Product fields pass through.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_add_stage import fp_format_pkg::*; import pipe_ctrl_pkg::*; #(
	parameter int LANES = 4
) (
	input wire logic clk,
	input wire logic reset,

	input wire logic s2_valid,
	input wire logic [OP_WIDTH-1:0] s2_op,
	input wire logic [THREAD_IDX_WIDTH-1:0] s2_thread_idx,
	input wire logic [LANES-1:0] s2_mask,
	input wire logic [LANES-1:0][SIG_WIDTH-1:0] s2_significand_le,
	input wire logic [LANES-1:0][SIG_WIDTH-1:0] s2_significand_se,
	input wire logic [LANES-1:0][EXP_WIDTH-1:0] s2_add_exponent,
	input wire logic [LANES-1:0] s2_add_sign,
	input wire logic [LANES-1:0] s2_logical_subtract,
	input wire logic [LANES-1:0] s2_guard,
	input wire logic [LANES-1:0] s2_round,
	input wire logic [LANES-1:0] s2_sticky,
	input wire logic [LANES-1:0][PROD_WIDTH-1:0] s2_product,
	input wire logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s2_mul_exponent,
	input wire logic [LANES-1:0] s2_mul_sign,
	input wire logic [LANES-1:0] s2_result_is_inf,
	input wire logic [LANES-1:0] s2_result_is_nan,

	output logic s3_valid,
	output logic [OP_WIDTH-1:0] s3_op,
	output logic [THREAD_IDX_WIDTH-1:0] s3_thread_idx,
	output logic [LANES-1:0] s3_mask,
	output logic [LANES-1:0][SUM_WIDTH-1:0] s3_sum,
	output logic [LANES-1:0][EXP_WIDTH-1:0] s3_add_exponent,
	output logic [LANES-1:0] s3_add_sign,
	output logic [LANES-1:0][PROD_WIDTH-1:0] s3_product,
	output logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s3_mul_exponent,
	output logic [LANES-1:0] s3_mul_sign,
	output logic [LANES-1:0] s3_result_is_inf,
	output logic [LANES-1:0] s3_result_is_nan
);

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic [SUM_WIDTH-1:0] ext_le;
			logic [SUM_WIDTH-1:0] ext_se;
			logic [SUM_WIDTH-1:0] sum;

			assign ext_le = {1'b0, s2_significand_le[lane], 3'b000};
			assign ext_se = {1'b0, s2_significand_se[lane], s2_guard[lane],
				s2_round[lane], s2_sticky[lane]};
			// The larger operand is on the left, so a difference never goes negative
			assign sum = s2_logical_subtract[lane] ? ext_le - ext_se : ext_le + ext_se;

			always_ff @(posedge clk)
			begin
				s3_sum[lane] <= sum;
				s3_add_exponent[lane] <= s2_add_exponent[lane];
				// Exact cancellation gives +0
				s3_add_sign[lane] <= s2_add_sign[lane]
					&& !(s2_logical_subtract[lane] && sum == '0);
				s3_product[lane] <= s2_product[lane];
				s3_mul_exponent[lane] <= s2_mul_exponent[lane];
				s3_mul_sign[lane] <= s2_mul_sign[lane];
				s3_result_is_inf[lane] <= s2_result_is_inf[lane];
				s3_result_is_nan[lane] <= s2_result_is_nan[lane];
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s3_valid <= 1'b0;
			s3_op <= '0;
			s3_thread_idx <= '0;
			s3_mask <= '0;
		end
		else
		begin
			s3_valid <= s2_valid;
			s3_op <= s2_op;
			s3_thread_idx <= s2_thread_idx;
			s3_mask <= s2_mask;
		end
	end

endmodule

`default_nettype wire

//--- hw/fp_align_stage.sv
/*
 * FP pipeline stage 2, align
 * Shifts the smaller significand right to the exponent of the larger
 * one and collects guard, round and sticky bits. Squashes the valid
 * bit of an instruction whose thread is rolled back.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_align_stage import fp_format_pkg::*; import pipe_ctrl_pkg::*; #(
	parameter int LANES = 4
) (
	input wire logic clk,
	input wire logic reset,

	// Rollback from writeback
	input wire logic rollback_en,
	input wire logic [THREAD_IDX_WIDTH-1:0] rollback_thread_idx,

	input wire logic s1_valid,
	input wire logic [OP_WIDTH-1:0] s1_op,
	input wire logic [THREAD_IDX_WIDTH-1:0] s1_thread_idx,
	input wire logic [LANES-1:0] s1_mask,
	input wire logic [LANES-1:0][SIG_WIDTH-1:0] s1_significand_le,
	input wire logic [LANES-1:0][SIG_WIDTH-1:0] s1_significand_se,
	input wire logic [LANES-1:0][SHIFT_WIDTH-1:0] s1_align_shift,
	input wire logic [LANES-1:0][EXP_WIDTH-1:0] s1_add_exponent,
	input wire logic [LANES-1:0] s1_add_sign,
	input wire logic [LANES-1:0] s1_logical_subtract,
	input wire logic [LANES-1:0][PROD_WIDTH-1:0] s1_product,
	input wire logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s1_mul_exponent,
	input wire logic [LANES-1:0] s1_mul_sign,
	input wire logic [LANES-1:0] s1_result_is_inf,
	input wire logic [LANES-1:0] s1_result_is_nan,

	output logic s2_valid,
	output logic [OP_WIDTH-1:0] s2_op,
	output logic [THREAD_IDX_WIDTH-1:0] s2_thread_idx,
	output logic [LANES-1:0] s2_mask,
	output logic [LANES-1:0][SIG_WIDTH-1:0] s2_significand_le,
	output logic [LANES-1:0][SIG_WIDTH-1:0] s2_significand_se,
	output logic [LANES-1:0][EXP_WIDTH-1:0] s2_add_exponent,
	output logic [LANES-1:0] s2_add_sign,
	output logic [LANES-1:0] s2_logical_subtract,
	output logic [LANES-1:0] s2_guard,
	output logic [LANES-1:0] s2_round,
	output logic [LANES-1:0] s2_sticky,
	output logic [LANES-1:0][PROD_WIDTH-1:0] s2_product,
	output logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s2_mul_exponent,
	output logic [LANES-1:0] s2_mul_sign,
	output logic [LANES-1:0] s2_result_is_inf,
	output logic [LANES-1:0] s2_result_is_nan
);

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic [SIG_WIDTH-1:0] aligned;
			logic guard;
			logic round;
			logic [GRS_WIDTH-3:0] sticky_bits;

			assign {aligned, guard, round, sticky_bits} =
				{s1_significand_se[lane], GRS_WIDTH'(0)} >> s1_align_shift[lane];

			always_ff @(posedge clk)
			begin
				s2_significand_le[lane] <= s1_significand_le[lane];
				s2_significand_se[lane] <= aligned;
				s2_add_exponent[lane] <= s1_add_exponent[lane];
				s2_add_sign[lane] <= s1_add_sign[lane];
				s2_logical_subtract[lane] <= s1_logical_subtract[lane];
				s2_guard[lane] <= guard;
				s2_round[lane] <= round;
				s2_sticky[lane] <= |sticky_bits;
				s2_product[lane] <= s1_product[lane];
				s2_mul_exponent[lane] <= s1_mul_exponent[lane];
				s2_mul_sign[lane] <= s1_mul_sign[lane];
				s2_result_is_inf[lane] <= s1_result_is_inf[lane];
				s2_result_is_nan[lane] <= s1_result_is_nan[lane];
			end

			// Stage 1 saturates the shift, so no significand bit is ever lost
			assert property (@(posedge clk) disable iff (reset)
				s1_valid |-> s1_align_shift[lane] <= SHIFT_WIDTH'(MAX_ALIGN_SHIFT));
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s2_valid <= 1'b0;
			s2_op <= '0;
			s2_thread_idx <= '0;
			s2_mask <= '0;
		end
		else
		begin
			s2_valid <= s1_valid && !(rollback_en && rollback_thread_idx == s1_thread_idx);
			s2_op <= s1_op;
			s2_thread_idx <= s1_thread_idx;
			s2_mask <= s1_mask;
		end
	end

endmodule

`default_nettype wire

//--- hw/fp_format_pkg.sv
/*
 * Single-precision format constants
 * Field widths of the IEEE 754 binary32 word, the widths of the
 * internal datapath and the special exponent encodings.
 */
`default_nettype none

package fp_format_pkg;

	localparam int FP_WIDTH = 32;
	localparam int EXP_WIDTH = 8;
	localparam int FRAC_WIDTH = 23;
	// Significand including the hidden bit
	localparam int SIG_WIDTH = FRAC_WIDTH + 1;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX = 255;

	// Guard, round and a 25-bit sticky field below the aligned significand
	localparam int GRS_WIDTH = 27;
	localparam int MAX_ALIGN_SHIFT = 27;
	localparam int SHIFT_WIDTH = $clog2(MAX_ALIGN_SHIFT + 1);

	// Carry, significand, guard, round and sticky
	localparam int SUM_WIDTH = SIG_WIDTH + 4;
	localparam int PROD_WIDTH = 2 * SIG_WIDTH;
	// Two extra bits hold product exponent overflow and underflow
	localparam int PROD_EXP_WIDTH = EXP_WIDTH + 2;

	localparam logic [FP_WIDTH-1:0] CANONICAL_NAN = 32'h7fc00000;

endpackage

`default_nettype wire

//--- hw/fp_round_stage.sv
/*
 * FP pipeline stage 4, round
 * Normalizes the sum or the product, rounds to nearest even, clamps
 * overflow to infinity and underflow to zero, applies the special
 * value flags and packs the single-precision result.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_round_stage import fp_format_pkg::*; import pipe_ctrl_pkg::*; #(
	parameter int LANES = 4
) (
	input wire logic clk,
	input wire logic reset,

	input wire logic s3_valid,
	input wire logic [OP_WIDTH-1:0] s3_op,
	input wire logic [THREAD_IDX_WIDTH-1:0] s3_thread_idx,
	input wire logic [LANES-1:0] s3_mask,
	input wire logic [LANES-1:0][SUM_WIDTH-1:0] s3_sum,
	input wire logic [LANES-1:0][EXP_WIDTH-1:0] s3_add_exponent,
	input wire logic [LANES-1:0] s3_add_sign,
	input wire logic [LANES-1:0][PROD_WIDTH-1:0] s3_product,
	input wire logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s3_mul_exponent,
	input wire logic [LANES-1:0] s3_mul_sign,
	input wire logic [LANES-1:0] s3_result_is_inf,
	input wire logic [LANES-1:0] s3_result_is_nan,

	output logic out_valid,
	output logic [THREAD_IDX_WIDTH-1:0] out_thread_idx,
	output logic [LANES-1:0] out_mask,
	output logic [LANES-1:0][FP_WIDTH-1:0] out_result
);

	// Guard bit position of the product when its top bit is clear
	localparam int PROD_GUARD = PROD_WIDTH - SIG_WIDTH - 2;

	function automatic logic [SHIFT_WIDTH-1:0] leading_zeros(
		input logic [SUM_WIDTH-2:0] value);
		logic [SHIFT_WIDTH-1:0] count;
		count = SHIFT_WIDTH'(SUM_WIDTH - 1);
		for (int i = 0; i < SUM_WIDTH - 1; i++)
			if (value[i])
				count = SHIFT_WIDTH'(SUM_WIDTH - 2 - i);
		return count;
	endfunction

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic [SHIFT_WIDTH-1:0] lz;
			logic [SUM_WIDTH-2:0] norm_sum;
			logic [SIG_WIDTH-1:0] mant;
			logic guard;
			logic round;
			logic sticky;
			logic sign;
			logic is_zero;
			logic signed [PROD_EXP_WIDTH-1:0] exp_norm;
			logic signed [PROD_EXP_WIDTH-1:0] exp_final;
			logic [SIG_WIDTH:0] mant_rounded;
			logic [FP_WIDTH-1:0] result;

			always_comb
			begin
				lz = leading_zeros(s3_sum[lane][SUM_WIDTH-2:0]);
				norm_sum = s3_sum[lane][SUM_WIDTH-2:0] << lz;
				if (s3_op == OP_MUL)
				begin
					sign = s3_mul_sign[lane];
					is_zero = s3_product[lane][PROD_WIDTH-1 -: 2] == 2'b00;
					// Product of two significands lies in [1, 4)
					if (s3_product[lane][PROD_WIDTH-1])
					begin
						mant = s3_product[lane][PROD_WIDTH-1 -: SIG_WIDTH];
						guard = s3_product[lane][PROD_GUARD+1];
						round = s3_product[lane][PROD_GUARD];
						sticky = |s3_product[lane][PROD_GUARD-1:0];
						exp_norm = s3_mul_exponent[lane] + 1'b1;
					end
					else
					begin
						mant = s3_product[lane][PROD_WIDTH-2 -: SIG_WIDTH];
						guard = s3_product[lane][PROD_GUARD];
						round = s3_product[lane][PROD_GUARD-1];
						sticky = |s3_product[lane][PROD_GUARD-2:0];
						exp_norm = s3_mul_exponent[lane];
					end
				end
				else
				begin
					sign = s3_add_sign[lane];
					is_zero = s3_sum[lane] == '0;
					if (s3_sum[lane][SUM_WIDTH-1])
					begin
						// Carry out, shift right by one
						mant = s3_sum[lane][SUM_WIDTH-1 -: SIG_WIDTH];
						guard = s3_sum[lane][3];
						round = s3_sum[lane][2];
						sticky = |s3_sum[lane][1:0];
						exp_norm = PROD_EXP_WIDTH'(s3_add_exponent[lane]) + 1'b1;
					end
					else
					begin
						mant = norm_sum[SUM_WIDTH-2 -: SIG_WIDTH];
						guard = norm_sum[2];
						round = norm_sum[1];
						sticky = norm_sum[0];
						exp_norm = PROD_EXP_WIDTH'(s3_add_exponent[lane])
							- PROD_EXP_WIDTH'(lz);
					end
				end

				// Nearest even, a tie rounds up only onto an even significand
				mant_rounded = {1'b0, mant} + (guard & (round | sticky | mant[0]));
				// On a rounding carry the fraction bits are already all zero
				exp_final = exp_norm + mant_rounded[SIG_WIDTH];

				if (s3_result_is_nan[lane])
					result = CANONICAL_NAN;
				else if (s3_result_is_inf[lane] || exp_final >= EXP_MAX)
					result = {sign, EXP_WIDTH'(EXP_MAX), FRAC_WIDTH'(0)};
				else if (is_zero || exp_final <= 0)
					result = {sign, (FP_WIDTH - 1)'(0)};
				else
					result = {sign, exp_final[EXP_WIDTH-1:0], mant_rounded[FRAC_WIDTH-1:0]};
			end

			always_ff @(posedge clk)
				out_result[lane] <= result;
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_thread_idx <= '0;
			out_mask <= '0;
		end
		else
		begin
			out_valid <= s3_valid;
			out_thread_idx <= s3_thread_idx;
			out_mask <= s3_mask;
		end
	end

	// Valid comes out of a chain of reset registers, so it must be known
	assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid));

endmodule

`default_nettype wire

//--- hw/fp_unpack_stage.sv
/*
 * FP pipeline stage 1, unpack
 * Decodes both operands per lane, flushes denormals, orders the
 * operands by magnitude and computes the alignment shift. Also forms
 * the significand product and flags NaN and infinite results.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_unpack_stage import fp_format_pkg::*; import pipe_ctrl_pkg::*; #(
	parameter int LANES = 4
) (
	input wire logic clk,
	input wire logic reset,

	input wire logic in_valid,
	input wire logic [OP_WIDTH-1:0] in_op,
	input wire logic [THREAD_IDX_WIDTH-1:0] in_thread_idx,
	input wire logic [LANES-1:0] in_mask,
	input wire logic [LANES-1:0][FP_WIDTH-1:0] operand_a,
	input wire logic [LANES-1:0][FP_WIDTH-1:0] operand_b,

	output logic s1_valid,
	output logic [OP_WIDTH-1:0] s1_op,
	output logic [THREAD_IDX_WIDTH-1:0] s1_thread_idx,
	output logic [LANES-1:0] s1_mask,
	output logic [LANES-1:0][SIG_WIDTH-1:0] s1_significand_le,
	output logic [LANES-1:0][SIG_WIDTH-1:0] s1_significand_se,
	output logic [LANES-1:0][SHIFT_WIDTH-1:0] s1_align_shift,
	output logic [LANES-1:0][EXP_WIDTH-1:0] s1_add_exponent,
	output logic [LANES-1:0] s1_add_sign,
	output logic [LANES-1:0] s1_logical_subtract,
	output logic [LANES-1:0][PROD_WIDTH-1:0] s1_product,
	output logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s1_mul_exponent,
	output logic [LANES-1:0] s1_mul_sign,
	output logic [LANES-1:0] s1_result_is_inf,
	output logic [LANES-1:0] s1_result_is_nan
);

	logic is_mul;

	assign is_mul = in_op == OP_MUL;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic sign_a;
			logic sign_b;
			logic [EXP_WIDTH-1:0] exp_a;
			logic [EXP_WIDTH-1:0] exp_b;
			logic [FRAC_WIDTH-1:0] frac_a;
			logic [FRAC_WIDTH-1:0] frac_b;
			logic zero_a;
			logic zero_b;
			logic inf_a;
			logic inf_b;
			logic nan_a;
			logic nan_b;
			logic [SIG_WIDTH-1:0] sig_a;
			logic [SIG_WIDTH-1:0] sig_b;
			logic b_larger;
			logic [EXP_WIDTH-1:0] exp_diff;
			logic logical_subtract;
			logic nan_result;

			assign sign_a = operand_a[lane][FP_WIDTH-1];
			// Subtraction is an add with the sign of b inverted
			assign sign_b = operand_b[lane][FP_WIDTH-1] ^ (in_op == OP_SUB);
			assign exp_a = operand_a[lane][FP_WIDTH-2 -: EXP_WIDTH];
			assign exp_b = operand_b[lane][FP_WIDTH-2 -: EXP_WIDTH];
			assign frac_a = operand_a[lane][FRAC_WIDTH-1:0];
			assign frac_b = operand_b[lane][FRAC_WIDTH-1:0];

			// Denormals are flushed, so a zero exponent means zero
			assign zero_a = exp_a == '0;
			assign zero_b = exp_b == '0;
			assign inf_a = exp_a == EXP_MAX && frac_a == '0;
			assign inf_b = exp_b == EXP_MAX && frac_b == '0;
			assign nan_a = exp_a == EXP_MAX && frac_a != '0;
			assign nan_b = exp_b == EXP_MAX && frac_b != '0;
			assign sig_a = zero_a ? '0 : {1'b1, frac_a};
			assign sig_b = zero_b ? '0 : {1'b1, frac_b};

			assign b_larger = {exp_b, frac_b & {FRAC_WIDTH{!zero_b}}}
				> {exp_a, frac_a & {FRAC_WIDTH{!zero_a}}};
			assign exp_diff = b_larger ? exp_b - exp_a : exp_a - exp_b;
			assign logical_subtract = sign_a ^ sign_b;

			// inf - inf and 0 * inf have no defined value
			assign nan_result = nan_a || nan_b || (is_mul
				? (inf_a && zero_b) || (inf_b && zero_a)
				: inf_a && inf_b && logical_subtract);

			always_ff @(posedge clk)
			begin
				s1_significand_le[lane] <= b_larger ? sig_b : sig_a;
				s1_significand_se[lane] <= b_larger ? sig_a : sig_b;
				s1_align_shift[lane] <= exp_diff > MAX_ALIGN_SHIFT
					? SHIFT_WIDTH'(MAX_ALIGN_SHIFT) : exp_diff[SHIFT_WIDTH-1:0];
				s1_add_exponent[lane] <= b_larger ? exp_b : exp_a;
				s1_add_sign[lane] <= b_larger ? sign_b : sign_a;
				s1_logical_subtract[lane] <= logical_subtract;
				s1_product[lane] <= sig_a * sig_b;
				s1_mul_exponent[lane] <= PROD_EXP_WIDTH'(exp_a) + PROD_EXP_WIDTH'(exp_b)
					- PROD_EXP_WIDTH'(EXP_BIAS);
				s1_mul_sign[lane] <= sign_a ^ sign_b;
				s1_result_is_nan[lane] <= nan_result;
				s1_result_is_inf[lane] <= !nan_result && (inf_a || inf_b);
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s1_op <= '0;
			s1_thread_idx <= '0;
			s1_mask <= '0;
		end
		else
		begin
			s1_valid <= in_valid;
			s1_op <= in_op;
			s1_thread_idx <= in_thread_idx;
			s1_mask <= in_mask;
		end
	end

endmodule

`default_nettype wire

//--- hw/fp_vector_pipe.sv
/*
 * Vector floating-point pipeline
 * Four registered stages (unpack, align, add, round) for single
 * precision add, subtract and multiply on LANES lanes at once.
 * A result appears four cycles after issue.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_vector_pipe import fp_format_pkg::*; import pipe_ctrl_pkg::*; #(
	parameter int LANES = 4
) (
	input wire logic clk,
	input wire logic reset,

	input wire logic in_valid,
	input wire logic [OP_WIDTH-1:0] in_op,
	input wire logic [THREAD_IDX_WIDTH-1:0] in_thread_idx,
	input wire logic [LANES-1:0] in_mask,
	input wire logic [LANES-1:0][FP_WIDTH-1:0] operand_a,
	input wire logic [LANES-1:0][FP_WIDTH-1:0] operand_b,

	// Rollback pulse from writeback
	input wire logic rollback_en,
	input wire logic [THREAD_IDX_WIDTH-1:0] rollback_thread_idx,

	output logic out_valid,
	output logic [THREAD_IDX_WIDTH-1:0] out_thread_idx,
	output logic [LANES-1:0] out_mask,
	output logic [LANES-1:0][FP_WIDTH-1:0] out_result
);

	// Stage 1 to stage 2
	logic s1_valid;
	logic [OP_WIDTH-1:0] s1_op;
	logic [THREAD_IDX_WIDTH-1:0] s1_thread_idx;
	logic [LANES-1:0] s1_mask;
	logic [LANES-1:0][SIG_WIDTH-1:0] s1_significand_le;
	logic [LANES-1:0][SIG_WIDTH-1:0] s1_significand_se;
	logic [LANES-1:0][SHIFT_WIDTH-1:0] s1_align_shift;
	logic [LANES-1:0][EXP_WIDTH-1:0] s1_add_exponent;
	logic [LANES-1:0] s1_add_sign;
	logic [LANES-1:0] s1_logical_subtract;
	logic [LANES-1:0][PROD_WIDTH-1:0] s1_product;
	logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s1_mul_exponent;
	logic [LANES-1:0] s1_mul_sign;
	logic [LANES-1:0] s1_result_is_inf;
	logic [LANES-1:0] s1_result_is_nan;

	// Stage 2 to stage 3
	logic s2_valid;
	logic [OP_WIDTH-1:0] s2_op;
	logic [THREAD_IDX_WIDTH-1:0] s2_thread_idx;
	logic [LANES-1:0] s2_mask;
	logic [LANES-1:0][SIG_WIDTH-1:0] s2_significand_le;
	logic [LANES-1:0][SIG_WIDTH-1:0] s2_significand_se;
	logic [LANES-1:0][EXP_WIDTH-1:0] s2_add_exponent;
	logic [LANES-1:0] s2_add_sign;
	logic [LANES-1:0] s2_logical_subtract;
	logic [LANES-1:0] s2_guard;
	logic [LANES-1:0] s2_round;
	logic [LANES-1:0] s2_sticky;
	logic [LANES-1:0][PROD_WIDTH-1:0] s2_product;
	logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s2_mul_exponent;
	logic [LANES-1:0] s2_mul_sign;
	logic [LANES-1:0] s2_result_is_inf;
	logic [LANES-1:0] s2_result_is_nan;

	// Stage 3 to stage 4
	logic s3_valid;
	logic [OP_WIDTH-1:0] s3_op;
	logic [THREAD_IDX_WIDTH-1:0] s3_thread_idx;
	logic [LANES-1:0] s3_mask;
	logic [LANES-1:0][SUM_WIDTH-1:0] s3_sum;
	logic [LANES-1:0][EXP_WIDTH-1:0] s3_add_exponent;
	logic [LANES-1:0] s3_add_sign;
	logic [LANES-1:0][PROD_WIDTH-1:0] s3_product;
	logic [LANES-1:0][PROD_EXP_WIDTH-1:0] s3_mul_exponent;
	logic [LANES-1:0] s3_mul_sign;
	logic [LANES-1:0] s3_result_is_inf;
	logic [LANES-1:0] s3_result_is_nan;

	// Stage ports share their names with the nets above
	fp_unpack_stage #(.LANES(LANES)) unpack_stage (.*);

	fp_align_stage #(.LANES(LANES)) align_stage (.*);

	fp_add_stage #(.LANES(LANES)) add_stage (.*);

	fp_round_stage #(.LANES(LANES)) round_stage (.*);

endmodule

`default_nettype wire

//--- hw/pipe_ctrl_pkg.sv
/*
 * Pipeline control constants
 * Opcode encodings and the thread index width shared by all stages.
 */
`default_nettype none

package pipe_ctrl_pkg;

	localparam int OP_WIDTH = 2;

	localparam logic [OP_WIDTH-1:0] OP_ADD = 2'd0;
	localparam logic [OP_WIDTH-1:0] OP_SUB = 2'd1;
	localparam logic [OP_WIDTH-1:0] OP_MUL = 2'd2;

	localparam int THREAD_IDX_WIDTH = 2;

endpackage

`default_nettype wire

//--- list.f
hw/fp_format_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/fp_unpack_stage.sv
hw/fp_align_stage.sv
hw/fp_add_stage.sv
hw/fp_round_stage.sv
hw/fp_vector_pipe.sv
testbench/fp_vector_pipe_tb.sv

//--- testbench/fp_vector_pipe_tb.sv
/*
 * Testbench for the vector floating-point pipeline
 * Directed tests for add, subtract, multiply, rounding, special
 * values, back-to-back issue and rollback. Expected words are
 * single-precision constants worked out by hand.
 */
`timescale 1ns/10ps
`default_nettype none

module fp_vector_pipe_tb import fp_format_pkg::*; import pipe_ctrl_pkg::*; ();

	localparam int LANES = 4;
	// About 100 cycles of reset and tests, doubled for margin
	localparam int TIMEOUT_CYCLES = 200;

	logic clk;
	logic reset;
	logic in_valid;
	logic [OP_WIDTH-1:0] in_op;
	logic [THREAD_IDX_WIDTH-1:0] in_thread_idx;
	logic [LANES-1:0] in_mask;
	logic [LANES-1:0][FP_WIDTH-1:0] operand_a;
	logic [LANES-1:0][FP_WIDTH-1:0] operand_b;
	logic rollback_en;
	logic [THREAD_IDX_WIDTH-1:0] rollback_thread_idx;
	logic out_valid;
	logic [THREAD_IDX_WIDTH-1:0] out_thread_idx;
	logic [LANES-1:0] out_mask;
	logic [LANES-1:0][FP_WIDTH-1:0] out_result;

	int cycle_count = 0;

	fp_vector_pipe #(.LANES(LANES)) DUT (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_thread_idx(in_thread_idx),
		.in_mask(in_mask),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.out_valid(out_valid),
		.out_thread_idx(out_thread_idx),
		.out_mask(out_mask),
		.out_result(out_result)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_result(input int lane, input logic [FP_WIDTH-1:0] actual,
		input logic [FP_WIDTH-1:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t out_result[%0d] got %h expected %h",
				$time, lane, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_valid(input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t out_valid got %b expected %b", $time, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_thread(input logic [THREAD_IDX_WIDTH-1:0] actual,
		input logic [THREAD_IDX_WIDTH-1:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t out_thread_idx got %0d expected %0d",
				$time, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_mask(input logic [LANES-1:0] actual, input logic [LANES-1:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t out_mask got %b expected %b", $time, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_outputs(input logic [THREAD_IDX_WIDTH-1:0] thread,
		input logic [LANES-1:0] mask, input logic [LANES-1:0][FP_WIDTH-1:0] expected);
		check_valid(out_valid, 1'b1);
		check_thread(out_thread_idx, thread);
		check_mask(out_mask, mask);
		for (int lane = 0; lane < LANES; lane++)
			if (mask[lane])
				check_result(lane, out_result[lane], expected[lane]);
	endtask

	task automatic issue_instruction(input logic [OP_WIDTH-1:0] op,
		input logic [THREAD_IDX_WIDTH-1:0] thread, input logic [LANES-1:0] mask,
		input logic [LANES-1:0][FP_WIDTH-1:0] a, input logic [LANES-1:0][FP_WIDTH-1:0] b);
		@(posedge clk);
		in_valid <= 1'b1;
		in_op <= op;
		in_thread_idx <= thread;
		in_mask <= mask;
		operand_a <= a;
		operand_b <= b;
	endtask

	// One instruction at a time, result checked 4 cycles after issue
	task automatic run_vector(input logic [OP_WIDTH-1:0] op,
		input logic [LANES-1:0][FP_WIDTH-1:0] a, input logic [LANES-1:0][FP_WIDTH-1:0] b,
		input logic [LANES-1:0][FP_WIDTH-1:0] expected);
		logic [THREAD_IDX_WIDTH-1:0] thread;
		logic [LANES-1:0] mask;
		mask = LANES'($urandom);
		// Second pass covers the lanes the first one masked off
		for (int pass = 0; pass < 2; pass++)
		begin
			thread = THREAD_IDX_WIDTH'($urandom);
			issue_instruction(op, thread, mask, a, b);
			@(posedge clk);
			in_valid <= 1'b0;
			repeat (3) @(posedge clk);
			@(negedge clk);
			check_outputs(thread, mask, expected);
			mask = ~mask;
		end
	endtask

	// Lanes are listed from 3 down to 0 in every vector below
	task automatic add_exact();
		// 0.75+0.25, 100+0.125, 1+1, 1.5+2.25
		run_vector(OP_ADD,
			{32'h3f400000, 32'h42c80000, 32'h3f800000, 32'h3fc00000},
			{32'h3e800000, 32'h3e000000, 32'h3f800000, 32'h40100000},
			{32'h3f800000, 32'h42c84000, 32'h40000000, 32'h40700000});
	endtask

	task automatic subtract_cases();
		// 2-(-1.5), 1-0.75, 3-3, 5-7
		run_vector(OP_SUB,
			{32'h40000000, 32'h3f800000, 32'h40400000, 32'h40a00000},
			{32'hbfc00000, 32'h3f400000, 32'h40400000, 32'h40e00000},
			{32'h40600000, 32'h3e800000, 32'h00000000, 32'hc0000000});
	endtask

	task automatic multiply_cases();
		// 1.5*1.5, 2^100*2^100, 0.5*0.5, 3*-2.5
		run_vector(OP_MUL,
			{32'h3fc00000, 32'h71800000, 32'h3f000000, 32'h40400000},
			{32'h3fc00000, 32'h71800000, 32'h3f000000, 32'hc0200000},
			{32'h40100000, 32'h7f800000, 32'h3e800000, 32'hc0f00000});
	endtask

	task automatic round_nearest_even();
		// denormal+denormal, denormal+2^-126, 1+3*2^-24, 1+2^-24
		run_vector(OP_ADD,
			{32'h00400000, 32'h00400000, 32'h3f800000, 32'h3f800000},
			{32'h00000001, 32'h00800000, 32'h34400000, 32'h33800000},
			{32'h00000000, 32'h00800000, 32'h3f800002, 32'h3f800000});
	endtask

	task automatic special_values();
		// -inf+3, 3+inf, NaN+1, inf+(-inf)
		run_vector(OP_ADD,
			{32'hff800000, 32'h40400000, 32'h7f800001, 32'h7f800000},
			{32'h40400000, 32'h7f800000, 32'h3f800000, 32'hff800000},
			{32'hff800000, 32'h7f800000, CANONICAL_NAN, CANONICAL_NAN});
		// denormal*2, -inf*2, NaN*2, 0*inf
		run_vector(OP_MUL,
			{32'h00400000, 32'hff800000, 32'hffc00001, 32'h00000000},
			{32'h40000000, 32'h40000000, 32'h40000000, 32'h7f800000},
			{32'h00000000, 32'hff800000, CANONICAL_NAN, CANONICAL_NAN});
	endtask

	task automatic back_to_back_rollback();
		logic [OP_WIDTH-1:0] ops [4];
		logic [FP_WIDTH-1:0] a_words [4];
		logic [FP_WIDTH-1:0] b_words [4];
		logic [FP_WIDTH-1:0] expected_words [4];
		logic [THREAD_IDX_WIDTH-1:0] threads [4];
		logic [LANES-1:0] masks [4];
		// 1+1, 5-7, 3*-2.5, 1.5+2.25
		ops = '{OP_ADD, OP_SUB, OP_MUL, OP_ADD};
		a_words = '{32'h3f800000, 32'h40a00000, 32'h40400000, 32'h3fc00000};
		b_words = '{32'h3f800000, 32'h40e00000, 32'hc0200000, 32'h40100000};
		expected_words = '{32'h40000000, 32'hc0000000, 32'hc0f00000, 32'h40700000};

		for (int i = 0; i < 4; i++)
		begin
			threads[i] = THREAD_IDX_WIDTH'($urandom);
			masks[i] = LANES'($urandom);
			issue_instruction(ops[i], threads[i], masks[i],
				{LANES{a_words[i]}}, {LANES{b_words[i]}});
		end
		@(posedge clk);
		in_valid <= 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			check_outputs(threads[i], masks[i], {LANES{expected_words[i]}});
		end
		@(negedge clk);
		check_valid(out_valid, 1'b0);

		// Threads 1, 2 and 3 in a row, thread 2 rolled back while in stage 1
		for (int i = 0; i < 3; i++)
			issue_instruction(ops[i], THREAD_IDX_WIDTH'(i + 1), '1,
				{LANES{a_words[i]}}, {LANES{b_words[i]}});
		rollback_en <= 1'b1;
		rollback_thread_idx <= THREAD_IDX_WIDTH'(2);
		@(posedge clk);
		in_valid <= 1'b0;
		rollback_en <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_outputs(THREAD_IDX_WIDTH'(1), '1, {LANES{expected_words[0]}});
		@(negedge clk);
		check_valid(out_valid, 1'b0);
		@(negedge clk);
		check_outputs(THREAD_IDX_WIDTH'(3), '1, {LANES{expected_words[2]}});
	endtask

	initial
	begin
		void'($urandom(32'h28));
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = OP_ADD;
		in_thread_idx = '0;
		in_mask = '0;
		operand_a = '0;
		operand_b = '0;
		rollback_en = 1'b0;
		rollback_thread_idx = '0;

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_valid(out_valid, 1'b0);

		add_exact();
		subtract_cases();
		multiply_cases();
		round_nearest_even();
		special_values();
		back_to_back_rollback();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
